// File: verilog/bm_consts.svh
// Bit-manipulation unit constants
// Word, transaction-id and operation-code widths

`ifndef BM_CONSTS_SVH
`define BM_CONSTS_SVH

`define BM_XLEN          64 // Data word width
`define BM_TRANS_ID_BITS 3  // Scoreboard tag width
`define BM_OP_BITS       5  // Operation code width

`endif

// File: verilog/bm_pkg.sv
// Bit-manipulation unit types
// Operation codes, sub-function codes, data words and tags
`default_nettype none

`include "bm_consts.svh"

package bm_pkg;

	typedef logic [`BM_XLEN-1:0]          bm_word_t;
	typedef logic [`BM_TRANS_ID_BITS-1:0] bm_trans_id_t;

	// Codes 7 and 16 to 31 are free
	typedef enum logic [`BM_OP_BITS-1:0] {
		OP_ANDN  = 5'd0,
		OP_ORN   = 5'd1,
		OP_XNOR  = 5'd2,
		OP_MIN   = 5'd3,
		OP_MAX   = 5'd4,
		OP_MINU  = 5'd5,
		OP_MAXU  = 5'd6,
		OP_CLZ   = 5'd8,
		OP_CLZW  = 5'd9,
		OP_CTZ   = 5'd10,
		OP_CTZW  = 5'd11,
		OP_PCNT  = 5'd12,
		OP_PCNTW = 5'd13,
		OP_SEXTB = 5'd14,
		OP_SEXTH = 5'd15
	} bm_op_e;

	typedef enum logic [3:0] {
		FUNC_ANDN  = 4'h0,
		FUNC_ORN   = 4'h1,
		FUNC_XNOR  = 4'h2,
		FUNC_MIN   = 4'h3,
		FUNC_MAX   = 4'h4,
		FUNC_MINU  = 4'h5,
		FUNC_MAXU  = 4'h6,
		FUNC_CLZ   = 4'h8,
		FUNC_CLZW  = 4'h9,
		FUNC_CTZ   = 4'ha,
		FUNC_CTZW  = 4'hb,
		FUNC_PCNT  = 4'hc,
		FUNC_PCNTW = 4'hd,
		FUNC_SEXTB = 4'he,
		FUNC_SEXTH = 4'hf
	} bm_func_e;

endpackage

`default_nettype wire

// File: verilog/bm_op_decoder.sv
// Bit-manipulation operation decoder
// Sorts an operation code into a sub-unit and picks its sub-function
`timescale 1ns/1ps
`default_nettype none

module bm_op_decoder (
	input  bm_pkg::bm_op_e   operation_i,
	output logic             is_logic_o,
	output logic             is_bitcnt_o,
	output bm_pkg::bm_func_e func_o
);
	import bm_pkg::*;

	always_comb begin
		is_logic_o  = 1'b0;
		is_bitcnt_o = 1'b0;
		func_o      = FUNC_ANDN; // Don't care when no strobe is set
		case (operation_i)
			OP_ANDN: begin
				is_logic_o = 1'b1;
				func_o     = FUNC_ANDN;
			end
			OP_ORN: begin
				is_logic_o = 1'b1;
				func_o     = FUNC_ORN;
			end
			OP_XNOR: begin
				is_logic_o = 1'b1;
				func_o     = FUNC_XNOR;
			end
			OP_MIN: begin
				is_logic_o = 1'b1;
				func_o     = FUNC_MIN;
			end
			OP_MAX: begin
				is_logic_o = 1'b1;
				func_o     = FUNC_MAX;
			end
			OP_MINU: begin
				is_logic_o = 1'b1;
				func_o     = FUNC_MINU;
			end
			OP_MAXU: begin
				is_logic_o = 1'b1;
				func_o     = FUNC_MAXU;
			end
			OP_CLZ: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_CLZ;
			end
			OP_CLZW: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_CLZW;
			end
			OP_CTZ: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_CTZ;
			end
			OP_CTZW: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_CTZW;
			end
			OP_PCNT: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_PCNT;
			end
			OP_PCNTW: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_PCNTW;
			end
			OP_SEXTB: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_SEXTB;
			end
			OP_SEXTH: begin
				is_bitcnt_o = 1'b1;
				func_o      = FUNC_SEXTH;
			end
			default: begin
				is_logic_o  = 1'b0; // Unknown code, dropped by the issue stage
				is_bitcnt_o = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/bm_issue_stage.sv
// Bit-manipulation issue stage
// Registers operands and tag on acceptance, starts the decoded sub-unit
// and holds off new input until that sub-unit delivers
`timescale 1ns/1ps
`default_nettype none

module bm_issue_stage (
	input  logic                 clock,
	input  logic                 clear_i,
	input  logic                 valid_i,
	input  logic                 is_logic_i,
	input  logic                 is_bitcnt_i,
	input  bm_pkg::bm_func_e     func_i,
	input  bm_pkg::bm_word_t     operand_a_i,
	input  bm_pkg::bm_word_t     operand_b_i,
	input  bm_pkg::bm_trans_id_t trans_id_i,
	input  logic                 unit_done_i,
	output logic                 ready_o,
	output logic                 logic_start_o,
	output logic                 bitcnt_start_o,
	output bm_pkg::bm_func_e     func_o,
	output bm_pkg::bm_word_t     rs1_o,
	output bm_pkg::bm_word_t     rs2_o,
	output bm_pkg::bm_trans_id_t trans_id_o
);
	logic accept;
	logic busy;
	logic busy_q;

	assign accept = valid_i && ready_o;

	// Busy from start until the unit's done strobe
	always_comb begin
		busy = busy_q;
		if (logic_start_o || bitcnt_start_o)
			busy = 1'b1;
		if (unit_done_i)
			busy = 1'b0; // Frees the input in the done cycle
	end

	assign ready_o = !busy;

	always_ff @(posedge clock) begin
		if (clear_i) begin
			logic_start_o  <= 1'b0;
			bitcnt_start_o <= 1'b0;
			busy_q         <= 1'b0;
		end else begin
			logic_start_o  <= accept && is_logic_i;
			bitcnt_start_o <= accept && is_bitcnt_i; // No strobe for unknown codes
			busy_q         <= busy;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			func_o     <= func_i;
			rs1_o      <= operand_a_i;
			rs2_o      <= operand_b_i;
			trans_id_o <= trans_id_i; // Held until the result stage takes it
		end
	end

endmodule

`default_nettype wire

// File: verilog/bm_logic_unit.sv
// Logic/compare sub-unit
// ANDN, ORN, XNOR and signed or unsigned MIN/MAX, one registered cycle
`timescale 1ns/1ps
`default_nettype none

module bm_logic_unit (
	input  logic             clock,
	input  logic             clear_i,
	input  logic             start_i,
	input  bm_pkg::bm_func_e func_i,
	input  bm_pkg::bm_word_t rs1_i,
	input  bm_pkg::bm_word_t rs2_i,
	output logic             done_o,
	output bm_pkg::bm_word_t result_o
);
	import bm_pkg::*;

	bm_word_t value;
	logic     lt_signed;
	logic     lt_unsigned;

	assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
	assign lt_unsigned = rs1_i < rs2_i;

	always_comb begin
		case (func_i)
			FUNC_ANDN: value = rs1_i & ~rs2_i;
			FUNC_ORN:  value = rs1_i | ~rs2_i;
			FUNC_XNOR: value = ~(rs1_i ^ rs2_i);
			FUNC_MIN:  value = lt_signed ? rs1_i : rs2_i;
			FUNC_MAX:  value = lt_signed ? rs2_i : rs1_i;
			FUNC_MINU: value = lt_unsigned ? rs1_i : rs2_i;
			FUNC_MAXU: value = lt_unsigned ? rs2_i : rs1_i;
			default:   value = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (clear_i)
			done_o <= 1'b0;
		else
			done_o <= start_i;
	end

	always_ff @(posedge clock) begin
		if (start_i)
			result_o <= value;
	end

endmodule

`default_nettype wire

// File: verilog/bm_bitcnt_unit.sv
// Bit-count sub-unit
// Leading and trailing zero count, population count and byte or
// halfword sign extension, one registered cycle
`timescale 1ns/1ps
`default_nettype none

`include "bm_consts.svh"

module bm_bitcnt_unit (
	input  logic             clock,
	input  logic             clear_i,
	input  logic             start_i,
	input  bm_pkg::bm_func_e func_i,
	input  bm_pkg::bm_word_t rs1_i,
	output logic             done_o,
	output bm_pkg::bm_word_t result_o
);
	import bm_pkg::*;

	localparam int CNT_W = $clog2(`BM_XLEN) + 1; // Holds 0 to 64

	logic [CNT_W-1:0] clz_d, ctz_d, pcnt_d;
	logic [CNT_W-2:0] clz_w, ctz_w, pcnt_w; // Low 32-bit forms
	bm_word_t         value;

	always_comb begin
		clz_d  = CNT_W'(`BM_XLEN);
		ctz_d  = CNT_W'(`BM_XLEN);
		pcnt_d = '0;
		for (int i = 0; i < `BM_XLEN; i++) begin
			if (rs1_i[i])
				clz_d = CNT_W'(`BM_XLEN - 1 - i); // Highest set bit wins
			pcnt_d = pcnt_d + CNT_W'(rs1_i[i]);
		end
		for (int i = `BM_XLEN - 1; i >= 0; i--) begin
			if (rs1_i[i])
				ctz_d = CNT_W'(i); // Lowest set bit wins
		end
	end

	always_comb begin
		clz_w  = (CNT_W-1)'(`BM_XLEN / 2);
		ctz_w  = (CNT_W-1)'(`BM_XLEN / 2);
		pcnt_w = '0;
		for (int i = 0; i < `BM_XLEN / 2; i++) begin
			if (rs1_i[i])
				clz_w = (CNT_W-1)'(`BM_XLEN / 2 - 1 - i);
			pcnt_w = pcnt_w + (CNT_W-1)'(rs1_i[i]);
		end
		for (int i = `BM_XLEN / 2 - 1; i >= 0; i--) begin
			if (rs1_i[i])
				ctz_w = (CNT_W-1)'(i);
		end
	end

	always_comb begin
		case (func_i)
			FUNC_CLZ:   value = bm_word_t'(clz_d);
			FUNC_CLZW:  value = bm_word_t'(clz_w);
			FUNC_CTZ:   value = bm_word_t'(ctz_d);
			FUNC_CTZW:  value = bm_word_t'(ctz_w);
			FUNC_PCNT:  value = bm_word_t'(pcnt_d);
			FUNC_PCNTW: value = bm_word_t'(pcnt_w);
			FUNC_SEXTB: value = {{(`BM_XLEN-8){rs1_i[7]}}, rs1_i[7:0]};
			FUNC_SEXTH: value = {{(`BM_XLEN-16){rs1_i[15]}}, rs1_i[15:0]};
			default:    value = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (clear_i)
			done_o <= 1'b0;
		else
			done_o <= start_i;
	end

	always_ff @(posedge clock) begin
		if (start_i)
			result_o <= value;
	end

endmodule

`default_nettype wire

// File: verilog/bm_result_stage.sv
// Bit-manipulation result stage
// Picks the finished sub-unit's value, logic unit first, and registers it
// with the issue-stage tag for a one-cycle valid
`timescale 1ns/1ps
`default_nettype none

module bm_result_stage (
	input  logic                 clock,
	input  logic                 clear_i,
	input  logic                 logic_done_i,
	input  logic                 bitcnt_done_i,
	input  bm_pkg::bm_word_t     logic_result_i,
	input  bm_pkg::bm_word_t     bitcnt_result_i,
	input  bm_pkg::bm_trans_id_t trans_id_i,
	output logic                 unit_done_o,
	output logic                 valid_o,
	output bm_pkg::bm_word_t     result_o,
	output bm_pkg::bm_trans_id_t trans_id_o
);
	assign unit_done_o = logic_done_i || bitcnt_done_i;

	always_ff @(posedge clock) begin
		if (clear_i)
			valid_o <= 1'b0;
		else
			valid_o <= unit_done_o; // Single cycle, nothing stalls it
	end

	always_ff @(posedge clock) begin
		if (unit_done_o) begin
			if (logic_done_i)
				result_o <= logic_result_i;
			else
				result_o <= bitcnt_result_i;
			trans_id_o <= trans_id_i;
		end
	end

endmodule

`default_nettype wire

// File: verilog/bm_unit_top.sv
// Bit-manipulation functional unit, top level
// Decoder, issue stage, logic and bit-count sub-units and result stage
// Flush clears the pipeline like reset
`timescale 1ns/1ps
`default_nettype none

module bm_unit_top (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush_i,
	input  logic                 valid_i,
	input  bm_pkg::bm_op_e       operation_i,
	input  bm_pkg::bm_word_t     operand_a_i,
	input  bm_pkg::bm_word_t     operand_b_i,
	input  bm_pkg::bm_trans_id_t trans_id_i,
	output logic                 ready_o,
	output logic                 valid_o,
	output bm_pkg::bm_word_t     result_o,
	output bm_pkg::bm_trans_id_t trans_id_o
);
	import bm_pkg::*;

	logic         clear;
	logic         is_logic, is_bitcnt;
	bm_func_e     dec_func, iss_func;
	logic         logic_start, bitcnt_start;
	bm_word_t     rs1, rs2;
	bm_trans_id_t iss_trans_id;
	logic         logic_done, bitcnt_done, unit_done;
	bm_word_t     logic_result, bitcnt_result;

	assign clear = reset || flush_i; // Flush drops everything in flight

	bm_op_decoder u_decoder (
		.operation_i (operation_i),
		.is_logic_o  (is_logic),
		.is_bitcnt_o (is_bitcnt),
		.func_o      (dec_func)
	);

	bm_issue_stage u_issue (
		.clock          (clock),
		.clear_i        (clear),
		.valid_i        (valid_i),
		.is_logic_i     (is_logic),
		.is_bitcnt_i    (is_bitcnt),
		.func_i         (dec_func),
		.operand_a_i    (operand_a_i),
		.operand_b_i    (operand_b_i),
		.trans_id_i     (trans_id_i),
		.unit_done_i    (unit_done),
		.ready_o        (ready_o),
		.logic_start_o  (logic_start),
		.bitcnt_start_o (bitcnt_start),
		.func_o         (iss_func),
		.rs1_o          (rs1),
		.rs2_o          (rs2),
		.trans_id_o     (iss_trans_id)
	);

	bm_logic_unit u_logic (
		.clock    (clock),
		.clear_i  (clear),
		.start_i  (logic_start),
		.func_i   (iss_func),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.done_o   (logic_done),
		.result_o (logic_result)
	);

	bm_bitcnt_unit u_bitcnt (
		.clock    (clock),
		.clear_i  (clear),
		.start_i  (bitcnt_start),
		.func_i   (iss_func),
		.rs1_i    (rs1),
		.done_o   (bitcnt_done),
		.result_o (bitcnt_result)
	);

	bm_result_stage u_result (
		.clock           (clock),
		.clear_i         (clear),
		.logic_done_i    (logic_done),
		.bitcnt_done_i   (bitcnt_done),
		.logic_result_i  (logic_result),
		.bitcnt_result_i (bitcnt_result),
		.trans_id_i      (iss_trans_id),
		.unit_done_o     (unit_done),
		.valid_o         (valid_o),
		.result_o        (result_o),
		.trans_id_o      (trans_id_o)
	);

endmodule

`default_nettype wire

// File: verif/bm_unit_chk.sv
// Bit-manipulation unit protocol assertions
// Bound into the top level; covers ready after acceptance and valid timing
`timescale 1ns/1ps
`default_nettype none

module bm_unit_chk (
	input logic clock,
	input logic reset,
	input logic flush_i,
	input logic in_valid_i,
	input logic dut_ready_i,
	input logic is_logic_i,
	input logic is_bitcnt_i,
	input logic dut_valid_i
);
	logic accept_known;
	int   fail_count = 0; // Failed assertions so far

	// Unknown codes are accepted but start nothing
	assign accept_known = in_valid_i && dut_ready_i && (is_logic_i || is_bitcnt_i) && !flush_i;

	ready_low_after_accept: assert property (@(posedge clock) disable iff (reset)
		accept_known |=> !dut_ready_i)
		else begin
			$error("ready_o high in the cycle after an acceptance");
			fail_count++;
		end

	valid_single_cycle: assert property (@(posedge clock) disable iff (reset)
		dut_valid_i |=> !dut_valid_i)
		else begin
			$error("valid_o high in two consecutive cycles");
			fail_count++;
		end

	valid_low_in_reset: assert property (@(posedge clock)
		reset |=> !dut_valid_i)
		else begin
			$error("valid_o high while reset is applied");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: verif/bm_tb_clock.sv
// Testbench clock and reset generator
// Free-running clock, reset held high for the first few cycles
`timescale 1ns/1ps
`default_nettype none

module bm_tb_clock #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0; // Released just after the last reset edge
	end

endmodule

`default_nettype wire

// File: verif/bm_tb_checker.sv
// Bit-manipulation unit scoreboard
// Predicts every accepted operation, compares results in order
// and prints one line per finished test
`timescale 1ns/1ps
`default_nettype none

`include "bm_consts.svh"

module bm_tb_checker (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush_i,
	input  logic                 valid_i,
	input  logic                 ready_i,
	input  bm_pkg::bm_op_e       operation_i,
	input  bm_pkg::bm_word_t     operand_a_i,
	input  bm_pkg::bm_word_t     operand_b_i,
	input  bm_pkg::bm_trans_id_t trans_id_i,
	input  logic                 result_valid_i,
	input  bm_pkg::bm_word_t     result_i,
	input  bm_pkg::bm_trans_id_t result_id_i,
	input  int                   test_id_i,
	input  logic                 test_end_i,
	input  int                   tb_errors_i,
	output int                   errors_o,
	output int                   checked_o,
	output int                   pending_o
);
	import bm_pkg::*;

	logic [`BM_TRANS_ID_BITS+`BM_XLEN-1:0] exp_q [$]; // {tag, value}
	logic [`BM_TRANS_ID_BITS+`BM_XLEN-1:0] entry;
	int errors = 0;
	int checked = 0;
	int pending = 0;
	int mark_errors = 0;
	int mark_checked = 0;

	assign errors_o  = errors;
	assign checked_o = checked;
	assign pending_o = pending;

	function automatic string test_label(input int id);
		case (id)
			1: return "logic_ops";
			2: return "bitcnt_ops";
			3: return "latency";
			4: return "back_to_back";
			5: return "unknown_code";
			6: return "flush";
			default: return "setup";
		endcase
	endfunction

	// Codes 7 and 16 and up carry no operation
	function automatic bit known_op(input bm_op_e op);
		return (op != 5'd7) && (op < 5'd16);
	endfunction

	function automatic bm_word_t ref_result(input bm_op_e op, input bm_word_t a,
			input bm_word_t b);
		bm_word_t r;
		int n;
		r = '0;
		n = 0;
		case (op)
			OP_ANDN:  r = a & ~b;
			OP_ORN:   r = a | ~b;
			OP_XNOR:  r = ~(a ^ b);
			OP_MIN:   r = ($signed(a) < $signed(b)) ? a : b;
			OP_MAX:   r = ($signed(a) > $signed(b)) ? a : b;
			OP_MINU:  r = (a < b) ? a : b;
			OP_MAXU:  r = (a > b) ? a : b;
			OP_CLZ: begin
				while (n < `BM_XLEN && !a[`BM_XLEN-1-n])
					n++;
				r = bm_word_t'(n);
			end
			OP_CLZW: begin
				while (n < `BM_XLEN / 2 && !a[`BM_XLEN/2-1-n])
					n++;
				r = bm_word_t'(n);
			end
			OP_CTZ: begin
				while (n < `BM_XLEN && !a[n])
					n++;
				r = bm_word_t'(n);
			end
			OP_CTZW: begin
				while (n < `BM_XLEN / 2 && !a[n])
					n++;
				r = bm_word_t'(n);
			end
			OP_PCNT: begin
				for (int i = 0; i < `BM_XLEN; i++)
					if (a[i])
						n++;
				r = bm_word_t'(n);
			end
			OP_PCNTW: begin
				for (int i = 0; i < `BM_XLEN / 2; i++)
					if (a[i])
						n++;
				r = bm_word_t'(n);
			end
			OP_SEXTB: begin
				r = bm_word_t'(a[7:0]);
				if (a[7])
					r[`BM_XLEN-1:8] = '1; // Negative byte fills the upper bits
			end
			OP_SEXTH: begin
				r = bm_word_t'(a[15:0]);
				if (a[15])
					r[`BM_XLEN-1:16] = '1;
			end
			default:  r = '0;
		endcase
		return r;
	endfunction

	always @(posedge clock) begin
		if (result_valid_i) begin
			checked++;
			if (exp_q.size() == 0) begin
				$display("Unexpected result %h with tag %0d in test %s",
					result_i, result_id_i, test_label(test_id_i));
				errors++;
			end else begin
				entry = exp_q.pop_front();
				if (entry != {result_id_i, result_i}) begin
					$display("[FAIL] %s: expected tag %0d value %h, actual tag %0d value %h",
						test_label(test_id_i), entry[`BM_TRANS_ID_BITS+`BM_XLEN-1:`BM_XLEN],
						entry[`BM_XLEN-1:0], result_id_i, result_i);
					errors++;
				end
			end
		end
		if (reset || flush_i)
			exp_q.delete(); // In-flight work is dropped
		else if (valid_i && ready_i && known_op(operation_i))
			exp_q.push_back({trans_id_i, ref_result(operation_i, operand_a_i, operand_b_i)});
		if (test_end_i) begin
			$display("test %0d %s: %0d results checked, %0d errors", test_id_i,
				test_label(test_id_i), checked - mark_checked,
				errors + tb_errors_i - mark_errors);
			mark_checked = checked;
			mark_errors  = errors + tb_errors_i;
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

// File: verif/bm_tb.sv
// Bit-manipulation unit testbench
// Drives logic, bit-count, latency, back-to-back, unknown-code and flush
// tests into the DUT; the checker does the comparing
`timescale 1ns/1ps
`default_nettype none

module bm_tb;
	import bm_pkg::*;

	localparam int CLK_PERIOD      = 20;
	localparam int RAND_PER_OP     = 6;
	localparam int LOGIC_OPS       = 7 * (9 + RAND_PER_OP);
	localparam int BITCNT_OPS      = 8 * (3 + RAND_PER_OP);
	localparam int B2B_OPS         = 40;
	localparam int TOTAL_OPS       = LOGIC_OPS + BITCNT_OPS + 1 + B2B_OPS + 3 + 2;
	localparam int WATCHDOG_CYCLES = TOTAL_OPS * 10 + 100;

	logic         clock;
	logic         reset;
	logic         flush_i;
	logic         valid_i;
	bm_op_e       operation_i;
	bm_word_t     operand_a_i;
	bm_word_t     operand_b_i;
	bm_trans_id_t trans_id_i;
	logic         ready_o;
	logic         valid_o;
	bm_word_t     result_o;
	bm_trans_id_t trans_id_o;
	logic         test_end;
	int           test_id;
	int           tb_errors;
	int           errors;
	int           checked;
	int           pending;
	int           seed;
	bm_word_t     logic_corner [3];
	bm_word_t     bitcnt_corner [3];

	bm_tb_clock #(.PERIOD(CLK_PERIOD)) clk0 (.clock(clock), .reset(reset));

	bm_unit_top dut0 (
		.clock       (clock),
		.reset       (reset),
		.flush_i     (flush_i),
		.valid_i     (valid_i),
		.operation_i (operation_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.trans_id_i  (trans_id_i),
		.ready_o     (ready_o),
		.valid_o     (valid_o),
		.result_o    (result_o),
		.trans_id_o  (trans_id_o)
	);

	bm_tb_checker chk0 (
		.clock          (clock),
		.reset          (reset),
		.flush_i        (flush_i),
		.valid_i        (valid_i),
		.ready_i        (ready_o),
		.operation_i    (operation_i),
		.operand_a_i    (operand_a_i),
		.operand_b_i    (operand_b_i),
		.trans_id_i     (trans_id_i),
		.result_valid_i (valid_o),
		.result_i       (result_o),
		.result_id_i    (trans_id_o),
		.test_id_i      (test_id),
		.test_end_i     (test_end),
		.tb_errors_i    (tb_errors),
		.errors_o       (errors),
		.checked_o      (checked),
		.pending_o      (pending)
	);

	bind bm_unit_top bm_unit_chk u_chk (
		.clock       (clock),
		.reset       (reset),
		.flush_i     (flush_i),
		.in_valid_i  (valid_i),
		.dut_ready_i (ready_o),
		.is_logic_i  (is_logic),
		.is_bitcnt_i (is_bitcnt),
		.dut_valid_i (valid_o)
	);

	function automatic bm_word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic bm_op_e pick_op();
		int idx;
		idx = $unsigned($random(seed)) % 15;
		return (idx < 7) ? bm_op_e'(5'(idx)) : bm_op_e'(5'(idx + 1)); // Skip free code 7
	endfunction

	// Holds valid_i until accepted, returns 1 ns after that edge
	task automatic send(input bm_op_e op, input bm_word_t a, input bm_word_t b,
			input bm_trans_id_t tag);
		operation_i = op;
		operand_a_i = a;
		operand_b_i = b;
		trans_id_i  = tag;
		valid_i     = 1'b1;
		@(posedge clock);
		while (!ready_o)
			@(posedge clock);
		#1;
	endtask

	task automatic finish_test();
		int waited;
		valid_i = 1'b0;
		waited  = 0;
		while (pending != 0 && waited < 10) begin
			@(posedge clock);
			#1;
			waited++;
		end
		test_end = 1'b1;
		@(posedge clock);
		#1;
		test_end = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int k;
		int i;
		int edges;
		int total;
		seed          = 32'hb6e8;
		flush_i       = 1'b0;
		valid_i       = 1'b0;
		operation_i   = OP_ANDN;
		operand_a_i   = '0;
		operand_b_i   = '0;
		trans_id_i    = '0;
		test_end      = 1'b0;
		test_id       = 0;
		tb_errors     = 0;
		logic_corner  = '{64'h0, '1, 64'h8000_0000_0000_0000};
		bitcnt_corner = '{64'h0, 64'h1, 64'h8000_0000}; // Zero, one, bit 31 only
		wait (!reset);
		@(posedge clock);
		#1;

		test_id = 1;
		for (k = 0; k < 7; k++) begin
			for (i = 0; i < 9; i++)
				send(bm_op_e'(5'(k)), logic_corner[i / 3], logic_corner[i % 3],
					bm_trans_id_t'(i));
			for (i = 0; i < RAND_PER_OP; i++)
				send(bm_op_e'(5'(k)), rand_word(), rand_word(), bm_trans_id_t'(i + k));
		end
		finish_test();

		test_id = 2;
		for (k = 8; k < 16; k++) begin
			for (i = 0; i < 3; i++)
				send(bm_op_e'(5'(k)), bitcnt_corner[i], rand_word(), bm_trans_id_t'(i));
			for (i = 0; i < RAND_PER_OP; i++)
				send(bm_op_e'(5'(k)), rand_word(), rand_word(), bm_trans_id_t'(i + k));
		end
		finish_test();

		test_id = 3;
		send(OP_MINU, rand_word(), rand_word(), 3'd5);
		valid_i = 1'b0;
		@(posedge clock);
		if (ready_o) begin
			$display("Latency test: ready_o still high in the cycle after acceptance");
			tb_errors++;
		end
		edges = 1;
		while (!valid_o && edges < 10) begin
			@(posedge clock);
			edges++;
		end
		if (edges != 3) begin
			$display("[FAIL] latency: expected valid_o %0d edges after acceptance, actual %0d",
				3, edges);
			tb_errors++;
		end
		#1;
		finish_test();

		test_id = 4;
		for (i = 0; i < B2B_OPS; i++)
			send(pick_op(), rand_word(), rand_word(), bm_trans_id_t'($random(seed)));
		finish_test();

		test_id = 5;
		send(bm_op_e'(5'd7), rand_word(), rand_word(), 3'd1);
		send(bm_op_e'(5'd23), rand_word(), rand_word(), 3'd2);
		valid_i = 1'b0;
		@(posedge clock);
		if (!ready_o) begin
			$display("Unknown code test: ready_o fell after a discarded code");
			tb_errors++;
		end
		#1;
		send(OP_XNOR, rand_word(), rand_word(), 3'd3);
		finish_test();

		test_id = 6;
		send(OP_CLZ, rand_word(), '0, 3'd4);
		valid_i = 1'b0;
		flush_i = 1'b1; // Operation sits in the bit-count unit
		@(posedge clock);
		#1;
		flush_i = 1'b0;
		repeat (4) @(posedge clock); // Any result here is flagged unexpected
		#1;
		send(OP_MAXU, rand_word(), rand_word(), 3'd6);
		finish_test();

		if (pending != 0) begin
			$display("missing results: %0d expected results never arrived", pending);
			tb_errors++;
		end
		total = errors + tb_errors + dut0.u_chk.fail_count;
		$display("Tests run: 6, results checked: %0d, errors: %0d", checked, total);
		if (total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/bm_pkg.sv
verilog/bm_op_decoder.sv
verilog/bm_issue_stage.sv
verilog/bm_logic_unit.sv
verilog/bm_bitcnt_unit.sv
verilog/bm_result_stage.sv
verilog/bm_unit_top.sv
verif/bm_unit_chk.sv
verif/bm_tb_clock.sv
verif/bm_tb_checker.sv
verif/bm_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the bit-manipulation unit testbench with Verilator
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module bm_tb -f filelist.f -o bm_sim

./obj_dir/bm_sim | tee sim.log

grep -q "TESTS PASSED" sim.log
